// File: muntjac_lite.f
hdl/core_pkg.sv
hdl/instr_frontend.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/exec_unit.sv
hdl/core_top.sv
hdl/pipeline_wrapper.sv
tests/tb_checker.sv
tests/tb_pipeline.sv

// File: tests/tb_pipeline.sv
// ####################
// muntjac_lite testbench
// Clock, reset, icache and dcache models, program
// images, an ISA reference model and a watchdog
// ####################

`timescale 1ns/10ps
`default_nettype none

module tb_pipeline;

  localparam int          NUM_TESTS = 6;
  localparam logic [31:0] NOP_WORD  = 32'h00000013;

  logic        clk_i;
  logic        arst_n_i;
  logic [63:0] boot_pc_i;
  logic        icache_req_valid_o;
  logic [63:0] icache_req_pc_o;
  logic        icache_resp_valid_i;
  logic [31:0] icache_resp_instr_i;
  logic        dcache_req_valid_o;
  logic        dcache_req_ready_i;
  logic [63:0] dcache_req_address_o;
  logic [63:0] dcache_req_value_o;
  logic        dcache_req_write_o;
  logic        dcache_resp_valid_i;
  logic [63:0] dcache_resp_value_i;
  logic [63:0] dbg_pc_o;

  logic [31:0] prog [0:63];
  int          prog_len;
  logic [63:0] boot_pc;
  int          stall_pct;
  string       test_name;
  logic [63:0] init_mem [0:63];
  logic [63:0] dmem [0:63];
  logic [63:0] ref_addr [$];
  logic [63:0] ref_value [$];
  integer      seed;
  int          i_wait;
  int          d_wait;
  logic [63:0] i_pc;
  logic [63:0] d_data;
  longint      watchdog_ns = 0;
  int          total_instr;
  int          errors;

  pipeline_wrapper dut (
    .clk_i                (clk_i),
    .arst_n_i             (arst_n_i),
    .boot_pc_i            (boot_pc_i),
    .icache_req_valid_o   (icache_req_valid_o),
    .icache_req_pc_o      (icache_req_pc_o),
    .icache_resp_valid_i  (icache_resp_valid_i),
    .icache_resp_instr_i  (icache_resp_instr_i),
    .dcache_req_valid_o   (dcache_req_valid_o),
    .dcache_req_ready_i   (dcache_req_ready_i),
    .dcache_req_address_o (dcache_req_address_o),
    .dcache_req_value_o   (dcache_req_value_o),
    .dcache_req_write_o   (dcache_req_write_o),
    .dcache_resp_valid_i  (dcache_resp_valid_i),
    .dcache_resp_value_i  (dcache_resp_value_i),
    .dbg_pc_o             (dbg_pc_o)
  );

  tb_checker store_check (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .req_valid_i   (dcache_req_valid_o),
    .req_ready_i   (dcache_req_ready_i),
    .req_write_i   (dcache_req_write_o),
    .req_address_i (dcache_req_address_o),
    .req_value_i   (dcache_req_value_o),
    .dbg_pc_i      (dbg_pc_o)
  );

  always #20 clk_i = ~clk_i;

  // RV64I instruction words
  function automatic logic [31:0] op_addi(logic [4:0] rd, logic [4:0] rs1, logic [31:0] imm);
    return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] op_add(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] op_sub(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] op_lui(logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] op_ld(logic [4:0] rd, logic [4:0] rs1, logic [31:0] imm);
    return {imm[11:0], rs1, 3'b011, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] op_sd(logic [4:0] rs2, logic [4:0] rs1, logic [31:0] imm);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] op_branch(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                            logic [31:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] op_jal(logic [4:0] rd, logic [31:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // Power-on data memory contents
  function automatic logic [63:0] mem_pattern(input logic [63:0] addr);
    return (addr * 64'h9E3779B97F4A7C15) ^ {addr[31:0], addr[63:32]};
  endfunction

  function automatic logic [31:0] fetch_word(input logic [63:0] pc);
    logic [63:0] off;
    logic [63:0] lim;
    off = pc - boot_pc;
    lim = 4 * prog_len;
    if (pc >= boot_pc && off < lim) begin
      return prog[off[7:2]];
    end
    return NOP_WORD;
  endfunction

  task automatic emit(input logic [31:0] word);
    prog[prog_len] = word;
    prog_len++;
  endtask

  task automatic load_program(input int t);
    prog_len  = 0;
    boot_pc   = 64'h0;
    stall_pct = 25;
    case (t)
      0: begin
        test_name = "arithmetic";
        emit(op_addi(1, 0, 100));
        emit(op_addi(2, 1, -7));
        emit(op_add(3, 1, 2));
        emit(op_sub(4, 2, 3));
        emit(op_lui(5, 20'hABCDE));
        emit(op_add(6, 5, 4));
        emit(op_sd(3, 0, 0));
        emit(op_sd(4, 0, 8));
        emit(op_sd(6, 0, 16));
      end
      1: begin
        test_name = "loads";
        emit(op_addi(1, 0, 64));
        emit(op_ld(2, 1, 0));
        emit(op_addi(3, 2, 1));
        emit(op_sd(3, 1, 8));
        emit(op_ld(4, 1, 8));
        emit(op_sub(5, 4, 2));
        emit(op_sd(5, 1, 16));
        emit(op_ld(6, 1, 24));
        emit(op_sd(6, 1, 32));
      end
      2: begin
        test_name = "branches";
        emit(op_addi(1, 0, 5));
        emit(op_addi(2, 0, 5));
        emit(op_branch(3'b000, 1, 2, 8));
        emit(op_sd(1, 0, 0));
        emit(op_branch(3'b001, 1, 2, 8));
        emit(op_sd(2, 0, 8));
        emit(op_jal(3, 8));
        emit(op_sd(1, 0, 16));
        emit(op_sd(3, 0, 24));
        emit(op_addi(2, 0, 6));
        emit(op_branch(3'b000, 1, 2, 8));
        emit(op_branch(3'b001, 1, 2, 8));
        emit(op_sd(2, 0, 32));
      end
      3: begin
        test_name = "backpressure";
        stall_pct = 60;
        emit(op_addi(1, 0, 1));
        for (int k = 0; k < 6; k++) begin
          emit(op_sd(1, 0, 8 * k));
          emit(op_addi(1, 1, 3));
        end
        emit(op_ld(2, 0, 8));
        emit(op_sd(2, 0, 48));
      end
      4: begin
        test_name = "boot_address";
        boot_pc   = 64'h1000;
        emit(op_addi(1, 0, -1));
        emit(op_lui(2, 20'h12345));
        emit(op_add(3, 1, 2));
        emit(op_sd(3, 0, 64));
        emit(op_jal(4, 8));
        emit(op_addi(4, 0, 9));
        emit(op_sd(4, 0, 72));
      end
      default: begin
        test_name = "unsupported";
        emit(op_addi(1, 0, 20));
        emit(32'h00000000);
        emit({12'h7FF, 5'd1, 3'b100, 5'd1, 7'b0010011});
        emit({12'h000, 5'd0, 3'b010, 5'd1, 7'b0000011});
        emit({7'd0, 5'd1, 5'd0, 3'b010, 5'd0, 7'b0100011});
        emit(32'hFFFFFFFF);
        emit(op_add(2, 1, 1));
        emit(op_sd(2, 0, 0));
      end
    endcase
    // Every image ends in a JAL to itself
    emit(op_jal(0, 0));
  endtask

  // ISA model of the nine instructions, other encodings do nothing
  function automatic logic [63:0] reference_run(input logic [63:0] boot);
    logic [63:0] regs [0:31];
    logic [63:0] mem [0:63];
    logic [63:0] pc;
    logic [63:0] next_pc;
    logic [63:0] addr;
    logic [31:0] w;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    ref_addr.delete();
    ref_value.delete();
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
      mem[i] = init_mem[i];
    end
    pc = boot;
    for (int step = 0; step < 4096; step++) begin
      w       = fetch_word(pc);
      rd      = w[11:7];
      rs1     = w[19:15];
      rs2     = w[24:20];
      f3      = w[14:12];
      next_pc = pc + 4;
      case (w[6:0])
        7'b0010011: if (f3 == 3'b000) regs[rd] = regs[rs1] + {{52{w[31]}}, w[31:20]};
        7'b0110011: begin
          if (f3 == 3'b000 && w[31:25] == 7'h00) regs[rd] = regs[rs1] + regs[rs2];
          else if (f3 == 3'b000 && w[31:25] == 7'h20) regs[rd] = regs[rs1] - regs[rs2];
        end
        7'b0110111: regs[rd] = {{32{w[31]}}, w[31:12], 12'b0};
        7'b0000011: begin
          addr = regs[rs1] + {{52{w[31]}}, w[31:20]};
          if (f3 == 3'b011) regs[rd] = mem[addr[8:3]];
        end
        7'b0100011: begin
          addr = regs[rs1] + {{52{w[31]}}, w[31:25], w[11:7]};
          if (f3 == 3'b011) begin
            mem[addr[8:3]] = regs[rs2];
            ref_addr.push_back(addr);
            ref_value.push_back(regs[rs2]);
          end
        end
        7'b1100011: begin
          addr = pc + {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
          if (f3 == 3'b000 && regs[rs1] == regs[rs2]) next_pc = addr;
          if (f3 == 3'b001 && regs[rs1] != regs[rs2]) next_pc = addr;
        end
        7'b1101111: begin
          addr = pc + {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
          if (addr == pc) return pc;
          regs[rd] = pc + 4;
          next_pc  = addr;
        end
        default: next_pc = pc + 4;
      endcase
      regs[0] = '0;
      pc      = next_pc;
    end
    return pc;
  endfunction

  // Cache models, driven on the falling edge
  always @(negedge clk_i) begin
    if (!arst_n_i) begin
      i_wait              = 0;
      d_wait              = 0;
      icache_resp_valid_i = 1'b0;
      dcache_resp_valid_i = 1'b0;
      dcache_req_ready_i  = 1'b1;
    end
    else begin
      icache_resp_valid_i = 1'b0;
      if (i_wait > 0) begin
        i_wait--;
        if (i_wait == 0) begin
          icache_resp_valid_i = 1'b1;
          icache_resp_instr_i = fetch_word(i_pc);
        end
      end
      if (icache_req_valid_o) begin
        i_pc   = icache_req_pc_o;
        i_wait = 1 + {$random(seed)} % 3;
      end
      dcache_resp_valid_i = 1'b0;
      if (d_wait > 0) begin
        d_wait--;
        if (d_wait == 0) begin
          dcache_resp_valid_i = 1'b1;
          dcache_resp_value_i = d_data;
        end
      end
      dcache_req_ready_i = ({$random(seed)} % 100) >= stall_pct;
      // Handshake completes at the coming rising edge
      if (dcache_req_valid_o && dcache_req_ready_i) begin
        if (dcache_req_write_o) begin
          dmem[dcache_req_address_o[8:3]] = dcache_req_value_o;
        end
        else begin
          d_data = dmem[dcache_req_address_o[8:3]];
          d_wait = 1 + {$random(seed)} % 2;
        end
      end
    end
  end

  task automatic run_test(input int t);
    logic [63:0] final_pc;
    logic [63:0] a;
    load_program(t);
    for (int i = 0; i < 64; i++) begin
      a           = i;
      init_mem[i] = mem_pattern(a << 3);
      dmem[i]     = init_mem[i];
    end
    final_pc = reference_run(boot_pc);
    store_check.begin_test(test_name, final_pc);
    for (int k = 0; k < ref_addr.size(); k++) begin
      store_check.expect_store(ref_addr[k], ref_value[k]);
    end
    @(negedge clk_i);
    arst_n_i  = 1'b0;
    boot_pc_i = boot_pc;
    repeat (5) @(negedge clk_i);
    arst_n_i = 1'b1;
    while (dbg_pc_o !== final_pc) begin
      @(negedge clk_i);
    end
    // Short window to catch a trailing extra store
    repeat (10) @(negedge clk_i);
    store_check.end_test();
  endtask

  initial begin
    seed                = 94;
    clk_i               = 1'b0;
    arst_n_i            = 1'b0;
    boot_pc_i           = '0;
    icache_resp_valid_i = 1'b0;
    icache_resp_instr_i = NOP_WORD;
    dcache_req_ready_i  = 1'b1;
    dcache_resp_valid_i = 1'b0;
    dcache_resp_value_i = '0;
    stall_pct           = 0;
    total_instr         = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      load_program(t);
      total_instr += prog_len;
    end
    watchdog_ns = total_instr * 200 * 40;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    store_check.report_counts(errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end
    else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    wait (watchdog_ns != 0);
    #(watchdog_ns);
    $display("Timeout after %0d ns, a program never reached its final PC", watchdog_ns);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/tb_checker.sv
// ####################
// Store and retire PC checker
// Compares every accepted dcache store and the
// final retire PC with the expected values
// ####################

`timescale 1ns/10ps
`default_nettype none

module tb_checker (
  input logic        clk_i,
  input logic        arst_n_i,
  input logic        req_valid_i,
  input logic        req_ready_i,
  input logic        req_write_i,
  input logic [63:0] req_address_i,
  input logic [63:0] req_value_i,
  input logic [63:0] dbg_pc_i
);

  logic [63:0] exp_addr [$];
  logic [63:0] exp_value [$];
  logic [63:0] want_addr;
  logic [63:0] want_value;
  logic [63:0] final_pc;
  string       name;
  int          test_errors = 0;
  int          total_errors = 0;
  int          stores_seen = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  task automatic begin_test(input string test_name, input logic [63:0] pc);
    name        = test_name;
    final_pc    = pc;
    test_errors = 0;
    stores_seen = 0;
    exp_addr.delete();
    exp_value.delete();
  endtask

  task automatic expect_store(input logic [63:0] addr, input logic [63:0] value);
    exp_addr.push_back(addr);
    exp_value.push_back(value);
  endtask

  task automatic end_test();
    if (exp_addr.size() != 0) begin
      $display("Test %s: %0d expected stores never reached the data cache",
               name, exp_addr.size());
      test_errors += exp_addr.size();
    end
    if (dbg_pc_i !== final_pc) begin
      $display("[ERROR] %0t: test %s retire PC ended at %h instead of %h", $time, name,
               dbg_pc_i, final_pc);
      test_errors++;
    end
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    total_errors += test_errors;
    $display("Test %-12s %s  stores %0d  errors %0d", name,
             (test_errors == 0) ? "ok" : "BAD", stores_seen, test_errors);
  endtask

  task automatic report_counts(output int errors);
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
    errors = total_errors;
  endtask

  // Handshake cycle of a store
  always @(posedge clk_i) begin
    if (arst_n_i && req_valid_i && req_ready_i && req_write_i) begin
      stores_seen++;
      if (exp_addr.size() == 0) begin
        $display("Test %s: extra store of %h to address %h that the program never makes",
                 name, req_value_i, req_address_i);
        test_errors++;
      end
      else begin
        want_addr  = exp_addr.pop_front();
        want_value = exp_value.pop_front();
        if (req_address_i !== want_addr || req_value_i !== want_value) begin
          $display("[ERROR] %0t: test %s store %h at %h, expected %h at %h", $time, name,
                   req_value_i, req_address_i, want_value, want_addr);
          test_errors++;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/pipeline_wrapper.sv
// ####################
// muntjac_lite top level
// Exposes the core's cache structs as flat
// ports for a test harness
// ####################

`timescale 1ns/10ps
`default_nettype none

module pipeline_wrapper (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  core_pkg::addr_t boot_pc_i,

  // Instruction cache
  output logic             icache_req_valid_o,
  output core_pkg::addr_t  icache_req_pc_o,
  input  logic             icache_resp_valid_i,
  input  core_pkg::instr_t icache_resp_instr_i,

  // Data cache
  output logic            dcache_req_valid_o,
  input  logic            dcache_req_ready_i,
  output core_pkg::addr_t dcache_req_address_o,
  output core_pkg::xlen_t dcache_req_value_o,
  output logic            dcache_req_write_o,
  input  logic            dcache_resp_valid_i,
  input  core_pkg::xlen_t dcache_resp_value_i,

  output core_pkg::addr_t dbg_pc_o
);

  import core_pkg::*;

  icache_req_t  icache_req;
  icache_resp_t icache_resp;
  dcache_req_t  dcache_req;
  dcache_resp_t dcache_resp;

  core_top core (
    .clk_i              (clk_i),
    .arst_n_i           (arst_n_i),
    .boot_pc_i          (boot_pc_i),
    .icache_req_o       (icache_req),
    .icache_resp_i      (icache_resp),
    .dcache_req_o       (dcache_req),
    .dcache_req_ready_i (dcache_req_ready_i),
    .dcache_resp_i      (dcache_resp),
    .dbg_pc_o           (dbg_pc_o)
  );

  // Instruction side
  assign icache_req_valid_o = icache_req.valid;
  assign icache_req_pc_o    = icache_req.pc;
  assign icache_resp.valid  = icache_resp_valid_i;
  assign icache_resp.instr  = icache_resp_instr_i;

  // Data side
  assign dcache_req_valid_o   = dcache_req.valid;
  assign dcache_req_address_o = dcache_req.address;
  assign dcache_req_value_o   = dcache_req.value;
  assign dcache_req_write_o   = dcache_req.write;
  assign dcache_resp.valid    = dcache_resp_valid_i;
  assign dcache_resp.value    = dcache_resp_value_i;

endmodule

`default_nettype wire

// File: hdl/core_top.sv
// ####################
// muntjac_lite core
// Frontend, decoder, register file and
// execute stage joined through structs
// ####################

`timescale 1ns/10ps
`default_nettype none

module core_top (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  core_pkg::addr_t        boot_pc_i,
  output core_pkg::icache_req_t  icache_req_o,
  input  core_pkg::icache_resp_t icache_resp_i,
  output core_pkg::dcache_req_t  dcache_req_o,
  input  logic                   dcache_req_ready_i,
  input  core_pkg::dcache_resp_t dcache_resp_i,
  output core_pkg::addr_t        dbg_pc_o
);

  import core_pkg::*;

  fetch_t    fetch;
  decoded_t  decoded;
  redirect_t redirect;
  logic      exec_ready;
  reg_idx_t  rs1;
  reg_idx_t  rs2;
  xlen_t     rs1_data;
  xlen_t     rs2_data;
  logic      rf_we;
  reg_idx_t  rf_rd;
  xlen_t     rf_wdata;

  instr_frontend frontend (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .boot_pc_i     (boot_pc_i),
    .icache_req_o  (icache_req_o),
    .icache_resp_i (icache_resp_i),
    .redirect_i    (redirect),
    .fetch_o       (fetch),
    .fetch_ready_i (exec_ready)
  );

  instr_decoder decoder (
    .fetch_i   (fetch),
    .decoded_o (decoded)
  );

  reg_file regfile (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (rf_we),
    .rd_i       (rf_rd),
    .rd_data_i  (rf_wdata)
  );

  exec_unit execute (
    .clk_i              (clk_i),
    .arst_n_i           (arst_n_i),
    .decoded_i          (decoded),
    .ready_o            (exec_ready),
    .rs1_o              (rs1),
    .rs2_o              (rs2),
    .rs1_data_i         (rs1_data),
    .rs2_data_i         (rs2_data),
    .rf_we_o            (rf_we),
    .rf_rd_o            (rf_rd),
    .rf_wdata_o         (rf_wdata),
    .redirect_o         (redirect),
    .dcache_req_o       (dcache_req_o),
    .dcache_req_ready_i (dcache_req_ready_i),
    .dcache_resp_i      (dcache_resp_i),
    .dbg_pc_o           (dbg_pc_o)
  );

endmodule

`default_nettype wire

// File: hdl/exec_unit.sv
// ####################
// Execute stage
// ALU, branch resolution, LD/SD sequencing on
// the dcache channel, writeback and retire PC
// ####################

`timescale 1ns/10ps
`default_nettype none

module exec_unit (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  core_pkg::decoded_t     decoded_i,
  output logic                   ready_o,
  output core_pkg::reg_idx_t     rs1_o,
  output core_pkg::reg_idx_t     rs2_o,
  input  core_pkg::xlen_t        rs1_data_i,
  input  core_pkg::xlen_t        rs2_data_i,
  output logic                   rf_we_o,
  output core_pkg::reg_idx_t     rf_rd_o,
  output core_pkg::xlen_t        rf_wdata_o,
  output core_pkg::redirect_t    redirect_o,
  output core_pkg::dcache_req_t  dcache_req_o,
  input  logic                   dcache_req_ready_i,
  input  core_pkg::dcache_resp_t dcache_resp_i,
  output core_pkg::addr_t        dbg_pc_o
);

  import core_pkg::*;

  exec_state_e state_q;
  logic        accept;
  logic        is_mem;
  logic        alu_we;
  logic        branch_taken;
  xlen_t       alu_result;
  addr_t       link_pc;
  addr_t       branch_target;
  addr_t       mem_addr;
  addr_t       req_addr_q;
  xlen_t       req_value_q;
  logic        req_write_q;
  reg_idx_t    mem_rd_q;
  addr_t       mem_pc_q;
  logic        redirect_valid_q;
  addr_t       redirect_target_q;
  addr_t       dbg_pc_q;

  // Hold off while a redirect is in flight so the wrong path is never taken
  assign ready_o = (state_q == EX_IDLE) && !redirect_valid_q;
  assign accept  = ready_o && decoded_i.valid;
  assign is_mem  = (decoded_i.op == OP_LD) || (decoded_i.op == OP_SD);

  assign rs1_o = decoded_i.rs1;
  assign rs2_o = decoded_i.rs2;

  assign link_pc       = decoded_i.pc + 64'd4;
  assign branch_target = decoded_i.pc + decoded_i.imm;
  assign mem_addr      = rs1_data_i + decoded_i.imm;

  always_comb begin
    alu_result   = '0;
    alu_we       = 1'b0;
    branch_taken = 1'b0;
    case (decoded_i.op)
      OP_ADD: begin
        // imm is zero for register ADD
        alu_result = rs1_data_i + rs2_data_i + decoded_i.imm;
        alu_we     = 1'b1;
      end
      OP_SUB: begin
        alu_result = rs1_data_i - rs2_data_i;
        alu_we     = 1'b1;
      end
      OP_LUI: begin
        alu_result = decoded_i.imm;
        alu_we     = 1'b1;
      end
      OP_BEQ: branch_taken = (rs1_data_i == rs2_data_i);
      OP_BNE: branch_taken = (rs1_data_i != rs2_data_i);
      OP_JAL: begin
        alu_result   = link_pc;
        alu_we       = 1'b1;
        branch_taken = 1'b1;
      end
      default: alu_result = '0;
    endcase
  end

  // Load data takes the write port while waiting
  always_comb begin
    rf_we_o    = accept && alu_we;
    rf_rd_o    = decoded_i.rd;
    rf_wdata_o = alu_result;
    if (state_q == EX_MEM_WAIT) begin
      rf_we_o    = dcache_resp_i.valid;
      rf_rd_o    = mem_rd_q;
      rf_wdata_o = dcache_resp_i.value;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q          <= EX_IDLE;
      redirect_valid_q <= 1'b0;
      dbg_pc_q         <= '0;
    end
    else begin
      redirect_valid_q <= accept && branch_taken;
      case (state_q)
        EX_IDLE: begin
          if (accept && is_mem) begin
            state_q <= EX_MEM_REQ;
          end
          else if (accept) begin
            dbg_pc_q <= decoded_i.pc;
          end
        end
        EX_MEM_REQ: begin
          if (dcache_req_ready_i && req_write_q) begin
            state_q  <= EX_IDLE;
            dbg_pc_q <= mem_pc_q;
          end
          else if (dcache_req_ready_i) begin
            state_q <= EX_MEM_WAIT;
          end
        end
        EX_MEM_WAIT: begin
          if (dcache_resp_i.valid) begin
            state_q  <= EX_IDLE;
            dbg_pc_q <= mem_pc_q;
          end
        end
        default: state_q <= EX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_addr_q  <= mem_addr;
      req_value_q <= rs2_data_i;
      req_write_q <= (decoded_i.op == OP_SD);
      mem_rd_q    <= decoded_i.rd;
      mem_pc_q    <= decoded_i.pc;
    end
    if (accept && branch_taken) begin
      redirect_target_q <= branch_target;
    end
  end

  assign redirect_o.valid  = redirect_valid_q;
  assign redirect_o.target = redirect_target_q;

  assign dcache_req_o.valid   = (state_q == EX_MEM_REQ);
  assign dcache_req_o.address = req_addr_q;
  assign dcache_req_o.value   = req_value_q;
  assign dcache_req_o.write   = req_write_q;

  assign dbg_pc_o = dbg_pc_q;

  // Request held until the cache takes it
  req_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    dcache_req_o.valid && !dcache_req_ready_i |=> dcache_req_o.valid
      && $stable(dcache_req_o.address) && $stable(dcache_req_o.value)
      && $stable(dcache_req_o.write));

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
// ####################
// Integer register file
// x1..x31 with x0 tied to zero, two
// asynchronous reads and one write
// ####################

`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  core_pkg::reg_idx_t rs1_i,
  input  core_pkg::reg_idx_t rs2_i,
  output core_pkg::xlen_t    rs1_data_o,
  output core_pkg::xlen_t    rs2_data_o,
  input  logic               we_i,
  input  core_pkg::reg_idx_t rd_i,
  input  core_pkg::xlen_t    rd_data_i
);

  import core_pkg::*;

  xlen_t regs_q [31:1];

  assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end
    else if (we_i && rd_i != '0) begin
      regs_q[rd_i] <= rd_data_i;
    end
  end

endmodule

`default_nettype wire

// File: hdl/instr_decoder.sv
// ####################
// Instruction decoder
// Maps a fetched RV64I word onto the reduced
// operation set with a sign-extended immediate
// ####################

`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
  input  core_pkg::fetch_t   fetch_i,
  output core_pkg::decoded_t decoded_o
);

  import core_pkg::*;

  instr_t   instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t    imm_i;
  xlen_t    imm_s;
  xlen_t    imm_b;
  xlen_t    imm_u;
  xlen_t    imm_j;

  assign instr  = fetch_i.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{52{instr[31]}}, instr[31:20]};
  assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
  assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    decoded_o.valid = fetch_i.valid;
    decoded_o.pc    = fetch_i.pc;
    decoded_o.op    = OP_NOP;
    decoded_o.rd    = instr[11:7];
    decoded_o.rs1   = instr[19:15];
    decoded_o.rs2   = instr[24:20];
    decoded_o.imm   = '0;

    case (opcode)
      OPC_OP_IMM: begin
        // ADDI runs as ADD with x0 in place of rs2
        if (funct3 == F3_ADD) begin
          decoded_o.op  = OP_ADD;
          decoded_o.rs2 = '0;
          decoded_o.imm = imm_i;
        end
      end
      OPC_OP: begin
        if (funct3 == F3_ADD && funct7 == F7_BASE) begin
          decoded_o.op = OP_ADD;
        end
        else if (funct3 == F3_ADD && funct7 == F7_ALT) begin
          decoded_o.op = OP_SUB;
        end
      end
      OPC_LUI: begin
        decoded_o.op  = OP_LUI;
        decoded_o.imm = imm_u;
      end
      OPC_LOAD: begin
        if (funct3 == F3_DOUBLE) begin
          decoded_o.op  = OP_LD;
          decoded_o.imm = imm_i;
        end
      end
      OPC_STORE: begin
        if (funct3 == F3_DOUBLE) begin
          decoded_o.op  = OP_SD;
          decoded_o.imm = imm_s;
        end
      end
      OPC_BRANCH: begin
        decoded_o.imm = imm_b;
        if (funct3 == F3_BEQ) begin
          decoded_o.op = OP_BEQ;
        end
        else if (funct3 == F3_BNE) begin
          decoded_o.op = OP_BNE;
        end
      end
      OPC_JAL: begin
        decoded_o.op  = OP_JAL;
        decoded_o.imm = imm_j;
      end
      default: begin
        decoded_o.op = OP_NOP;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/instr_frontend.sv
// ####################
// Instruction fetch frontend
// Generates fetch PCs, keeps one icache request in
// flight, buffers one instruction and flushes on
// redirect using an epoch bit
// ####################

`timescale 1ns/10ps
`default_nettype none

module instr_frontend (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  core_pkg::addr_t        boot_pc_i,
  output core_pkg::icache_req_t  icache_req_o,
  input  core_pkg::icache_resp_t icache_resp_i,
  input  core_pkg::redirect_t    redirect_i,
  output core_pkg::fetch_t       fetch_o,
  input  logic                   fetch_ready_i
);

  import core_pkg::*;

  addr_t  pc_q;
  addr_t  pend_pc_q;
  addr_t  buf_pc_q;
  instr_t buf_instr_q;
  logic   started_q;
  logic   pending_q;
  logic   pend_epoch_q;
  logic   epoch_q;
  logic   buf_valid_q;
  logic   deq;
  logic   issue;
  logic   resp_ok;

  assign deq = buf_valid_q && fetch_ready_i;

  // Only fetch when the buffer is guaranteed empty by the time the answer lands
  assign issue = started_q && !pending_q && (!buf_valid_q || deq) && !redirect_i.valid;

  // Stale answers from before a redirect are dropped
  assign resp_ok = icache_resp_i.valid && (pend_epoch_q == epoch_q) && !redirect_i.valid;

  assign icache_req_o.valid = issue;
  assign icache_req_o.pc    = pc_q;

  assign fetch_o.valid = buf_valid_q;
  assign fetch_o.pc    = buf_pc_q;
  assign fetch_o.instr = buf_instr_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      // Boot address follows the input while reset is held
      pc_q        <= boot_pc_i;
      started_q   <= 1'b0;
      pending_q   <= 1'b0;
      epoch_q     <= 1'b0;
      buf_valid_q <= 1'b0;
    end
    else begin
      started_q <= 1'b1;
      if (redirect_i.valid) begin
        pc_q    <= redirect_i.target;
        epoch_q <= ~epoch_q;
      end
      else if (issue) begin
        pc_q <= pc_q + 64'd4;
      end
      if (issue) begin
        pending_q <= 1'b1;
      end
      else if (icache_resp_i.valid) begin
        pending_q <= 1'b0;
      end
      if (redirect_i.valid) begin
        buf_valid_q <= 1'b0;
      end
      else if (resp_ok) begin
        buf_valid_q <= 1'b1;
      end
      else if (deq) begin
        buf_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      pend_pc_q    <= pc_q;
      pend_epoch_q <= epoch_q;
    end
    if (resp_ok) begin
      buf_pc_q    <= pend_pc_q;
      buf_instr_q <= icache_resp_i.instr;
    end
  end

  // One outstanding request until the cache answers
  single_req_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    icache_req_o.valid |=> (!icache_req_o.valid until_with icache_resp_i.valid));

  no_orphan_resp_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    icache_resp_i.valid |-> pending_q);

endmodule

`default_nettype wire

// File: hdl/core_pkg.sv
// ####################
// muntjac_lite core package
// Widths, RV64I opcodes, execute FSM states and
// the structs shared by frontend, decoder,
// execute stage and cache channels
// ####################

`default_nettype none

package core_pkg;

  localparam int unsigned XLEN = 64;
  localparam int unsigned ILEN = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [XLEN-1:0] addr_t;
  typedef logic [ILEN-1:0] instr_t;
  typedef logic [4:0]      reg_idx_t;

  // Major opcodes
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // Minor fields
  localparam logic [2:0] F3_ADD    = 3'b000;
  localparam logic [2:0] F3_DOUBLE = 3'b011;
  localparam logic [2:0] F3_BEQ    = 3'b000;
  localparam logic [2:0] F3_BNE    = 3'b001;
  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000;

  typedef enum logic [3:0] {
    OP_NOP,
    OP_ADD,
    OP_SUB,
    OP_LUI,
    OP_LD,
    OP_SD,
    OP_BEQ,
    OP_BNE,
    OP_JAL
  } op_e;

  typedef enum logic [1:0] {
    EX_IDLE,
    EX_MEM_REQ,
    EX_MEM_WAIT
  } exec_state_e;

  typedef struct packed {
    logic  valid;
    addr_t pc;
  } icache_req_t;

  typedef struct packed {
    logic   valid;
    instr_t instr;
  } icache_resp_t;

  typedef struct packed {
    logic  valid;
    addr_t address;
    xlen_t value;
    logic  write;
  } dcache_req_t;

  typedef struct packed {
    logic  valid;
    xlen_t value;
  } dcache_resp_t;

  typedef struct packed {
    logic   valid;
    addr_t  pc;
    instr_t instr;
  } fetch_t;

  typedef struct packed {
    logic     valid;
    op_e      op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    xlen_t    imm;
    addr_t    pc;
  } decoded_t;

  typedef struct packed {
    logic  valid;
    addr_t target;
  } redirect_t;

endpackage

`default_nettype wire
